//--- rtl/mem_bridge_defines.svh
`ifndef MEM_BRIDGE_DEFINES_SVH
`define MEM_BRIDGE_DEFINES_SVH

// Data path
`define MB_DATA_WIDTH 128
`define MB_STRB_WIDTH (`MB_DATA_WIDTH / 8)

// App port address, in app-side units
`define MB_ADDR_WIDTH 29

`define MB_ID_WIDTH 4

// Command code field of the DDR controller app port
`define MB_APP_CMD_WIDTH 3

// Queue depths
`define MB_CMD_QUEUE_DEPTH 4
`define MB_RD_QUEUE_DEPTH 4

`endif

//--- rtl/mem_bridge_pkg.sv
`include "mem_bridge_defines.svh"

package mem_bridge_pkg;

    typedef enum logic {
        RAM_OP_WRITE = 1'b0,
        RAM_OP_READ  = 1'b1
    } ram_op_e;

    // One single-beat RAM command
    typedef struct packed {
        ram_op_e                    op;
        logic                       last;
        logic [`MB_ID_WIDTH-1:0]    id;
        logic [`MB_ADDR_WIDTH-1:0]  addr;
        logic [`MB_DATA_WIDTH-1:0]  wr_data;
        logic [`MB_STRB_WIDTH-1:0]  wr_strb;
    } ram_cmd_t;

    typedef struct packed {
        logic [`MB_ID_WIDTH-1:0]    id;
        logic [`MB_DATA_WIDTH-1:0]  data;
        logic                       last;
    } rd_resp_t;

    typedef enum logic [`MB_APP_CMD_WIDTH-1:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1
    } app_cmd_e;

    // Mask bit set means the byte is not written
    typedef struct packed {
        logic [`MB_DATA_WIDTH-1:0]  data;
        logic [`MB_STRB_WIDTH-1:0]  mask;
    } app_wr_t;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_READ = 1'b1
    } seq_state_e;

endpackage

//--- rtl/cmd_queue.sv
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module cmd_queue (
    input  logic                     clk_if,
    input  logic                     resetn,
    input  mem_bridge_pkg::ram_cmd_t ram_cmd,
    input  logic                     ram_cmd_valid,
    output logic                     ram_cmd_ready,
    output mem_bridge_pkg::ram_cmd_t head_cmd,
    output logic                     head_valid,
    input  logic                     head_pop
);
    import mem_bridge_pkg::*;

    localparam int PTR_W = $clog2(`MB_CMD_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`MB_CMD_QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`MB_CMD_QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`MB_CMD_QUEUE_DEPTH);

    ram_cmd_t         mem [`MB_CMD_QUEUE_DEPTH];
    ram_cmd_t         push_cmd;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             push;
    logic             pop;

    assign push = ram_cmd_valid && ram_cmd_ready;
    assign pop  = head_pop && head_valid;

    assign head_valid = (count != '0);
    assign head_cmd   = mem[rd_ptr];

    // Reads carry no write payload
    always_comb begin
        push_cmd = ram_cmd;
        if (ram_cmd.op == RAM_OP_READ) begin
            push_cmd.wr_data = '0;
            push_cmd.wr_strb = '0;
        end
    end

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk_if) begin
        if (push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            ram_cmd_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // Ready for next cycle, from the post-update fill level
            ram_cmd_ready <= (count_next != FULL_CNT);
        end
    end

endmodule

//--- rtl/app_sequencer.sv
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module app_sequencer (
    input  logic                        clk_if,
    input  logic                        resetn,

    input  mem_bridge_pkg::ram_cmd_t    head_cmd,
    input  logic                        head_valid,
    output logic                        head_pop,

    input  logic                        app_cmd_ready,
    input  logic                        app_wdf_rdy,
    output mem_bridge_pkg::app_cmd_e    app_cmd,
    output logic [`MB_ADDR_WIDTH-1:0]   app_addr,
    output logic                        app_cmd_en,

    output mem_bridge_pkg::app_wr_t     app_wdf,
    output logic                        app_wdf_wren,
    output logic                        app_wdf_end,

    input  logic [`MB_DATA_WIDTH-1:0]   app_rd_data,
    input  logic                        app_rd_data_valid,

    input  logic                        rd_space,
    output logic                        rd_push,
    output mem_bridge_pkg::rd_resp_t    rd_push_resp
);
    import mem_bridge_pkg::*;

    seq_state_e              state;
    seq_state_e              state_next;
    logic                    head_is_read;
    logic                    issue_rd;
    logic                    issue_wr;
    logic [`MB_ID_WIDTH-1:0] rd_id_q;
    logic                    rd_last_q;

    assign head_is_read = (head_cmd.op == RAM_OP_READ);

    // A write needs both the command and write-data channels free
    assign issue_wr = (state == SEQ_IDLE) && head_valid && !head_is_read
                      && app_cmd_ready && app_wdf_rdy;
    // A read needs room for its response
    assign issue_rd = (state == SEQ_IDLE) && head_valid && head_is_read
                      && app_cmd_ready && rd_space;

    assign head_pop   = issue_wr || issue_rd;
    assign app_cmd_en = issue_wr || issue_rd;
    assign app_cmd    = head_is_read ? APP_CMD_READ : APP_CMD_WRITE;
    assign app_addr   = head_cmd.addr;

    // Write data and end go out with the command
    assign app_wdf_wren = issue_wr;
    assign app_wdf_end  = issue_wr;

    always_comb begin
        app_wdf.data = head_cmd.wr_data;
        app_wdf.mask = ~head_cmd.wr_strb;
    end

    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE: begin
                if (issue_rd) begin
                    state_next = SEQ_READ;
                end
            end
            SEQ_READ: begin
                // Single outstanding read, wait for its data
                if (app_rd_data_valid) begin
                    state_next = SEQ_IDLE;
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Tag of the read in flight
    always_ff @(posedge clk_if) begin
        if (issue_rd) begin
            rd_id_q   <= head_cmd.id;
            rd_last_q <= head_cmd.last;
        end
    end

    assign rd_push = (state == SEQ_READ) && app_rd_data_valid;

    always_comb begin
        rd_push_resp.id   = rd_id_q;
        rd_push_resp.data = app_rd_data;
        rd_push_resp.last = rd_last_q;
    end

endmodule

//--- rtl/read_return_queue.sv
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module read_return_queue (
    input  logic                     clk_if,
    input  logic                     resetn,
    input  logic                     rd_push,
    input  mem_bridge_pkg::rd_resp_t rd_push_resp,
    output logic                     rd_space,
    output mem_bridge_pkg::rd_resp_t rd_resp,
    output logic                     rd_resp_valid,
    input  logic                     rd_resp_ready
);
    import mem_bridge_pkg::*;

    localparam int PTR_W = $clog2(`MB_RD_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`MB_RD_QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`MB_RD_QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`MB_RD_QUEUE_DEPTH);

    rd_resp_t         mem [`MB_RD_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign rd_space      = (count < FULL_CNT);
    assign rd_resp_valid = (count != '0);
    assign rd_resp       = mem[rd_ptr];

    assign push = rd_push && rd_space;
    assign pop  = rd_resp_valid && rd_resp_ready;

    always_ff @(posedge clk_if) begin
        if (push) begin
            mem[wr_ptr] <= rd_push_resp;
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- rtl/mem_bridge_top.sv
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module mem_bridge_top (
    input  logic                        clk_if,
    input  logic                        resetn,

    // RAM command source
    input  mem_bridge_pkg::ram_cmd_t    ram_cmd,
    input  logic                        ram_cmd_valid,
    output logic                        ram_cmd_ready,

    // RAM response sink
    output mem_bridge_pkg::rd_resp_t    rd_resp,
    output logic                        rd_resp_valid,
    input  logic                        rd_resp_ready,

    // DDR controller app port
    input  logic                        app_cmd_ready,
    input  logic                        app_wdf_rdy,
    output mem_bridge_pkg::app_cmd_e    app_cmd,
    output logic [`MB_ADDR_WIDTH-1:0]   app_addr,
    output logic                        app_cmd_en,
    output mem_bridge_pkg::app_wr_t     app_wdf,
    output logic                        app_wdf_wren,
    output logic                        app_wdf_end,
    input  logic [`MB_DATA_WIDTH-1:0]   app_rd_data,
    input  logic                        app_rd_data_valid
);
    import mem_bridge_pkg::*;

    ram_cmd_t head_cmd;
    logic     head_valid;
    logic     head_pop;
    logic     rd_space;
    logic     rd_push;
    rd_resp_t rd_push_resp;

    cmd_queue i_cmd_queue (
        .clk_if        (clk_if),
        .resetn        (resetn),
        .ram_cmd       (ram_cmd),
        .ram_cmd_valid (ram_cmd_valid),
        .ram_cmd_ready (ram_cmd_ready),
        .head_cmd      (head_cmd),
        .head_valid    (head_valid),
        .head_pop      (head_pop)
    );

    app_sequencer i_app_sequencer (
        .clk_if            (clk_if),
        .resetn            (resetn),
        .head_cmd          (head_cmd),
        .head_valid        (head_valid),
        .head_pop          (head_pop),
        .app_cmd_ready     (app_cmd_ready),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_cmd           (app_cmd),
        .app_addr          (app_addr),
        .app_cmd_en        (app_cmd_en),
        .app_wdf           (app_wdf),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_end       (app_wdf_end),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .rd_space          (rd_space),
        .rd_push           (rd_push),
        .rd_push_resp      (rd_push_resp)
    );

    read_return_queue i_read_return_queue (
        .clk_if        (clk_if),
        .resetn        (resetn),
        .rd_push       (rd_push),
        .rd_push_resp  (rd_push_resp),
        .rd_space      (rd_space),
        .rd_resp       (rd_resp),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_ready (rd_resp_ready)
    );

endmodule

//--- sim/app_mem_model.sv
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module app_mem_model (
    input  logic                        clk_if,
    input  logic                        resetn,
    input  mem_bridge_pkg::app_cmd_e    app_cmd,
    input  logic [`MB_ADDR_WIDTH-1:0]   app_addr,
    input  logic                        app_cmd_en,
    input  mem_bridge_pkg::app_wr_t     app_wdf,
    input  logic                        app_wdf_wren,
    input  logic                        app_wdf_end,
    output logic                        app_cmd_ready,
    output logic                        app_wdf_rdy,
    output logic [`MB_DATA_WIDTH-1:0]   app_rd_data,
    output logic                        app_rd_data_valid
);
    import mem_bridge_pkg::*;

    logic [`MB_DATA_WIDTH-1:0] mem [logic [`MB_ADDR_WIDTH-1:0]];
    logic [`MB_DATA_WIDTH-1:0] wr_word;
    logic [`MB_DATA_WIDTH-1:0] rd_word;
    logic                      rd_pending;
    int unsigned               rd_wait;

    // Contents of a location never written
    function automatic logic [`MB_DATA_WIDTH-1:0] fill_word(
        input logic [`MB_ADDR_WIDTH-1:0] addr
    );
        logic [31:0] seed;
        seed = {3'b000, addr} ^ 32'h9e37_79b9;
        return {seed, ~seed, seed + 32'h1, seed ^ 32'hffff_0000};
    endfunction

    function automatic logic [`MB_DATA_WIDTH-1:0] read_word(
        input logic [`MB_ADDR_WIDTH-1:0] addr
    );
        return mem.exists(addr) ? mem[addr] : fill_word(addr);
    endfunction

    initial begin
        app_cmd_ready     = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
    end

    always @(posedge clk_if) begin
        if (!resetn) begin
            app_cmd_ready     <= 1'b0;
            app_wdf_rdy       <= 1'b0;
            app_rd_data       <= '0;
            app_rd_data_valid <= 1'b0;
            rd_pending        <= 1'b0;
            rd_wait           <= 0;
        end else begin
            app_cmd_ready     <= ($urandom % 4 != 0);
            app_wdf_rdy       <= ($urandom % 4 != 0);
            app_rd_data_valid <= 1'b0;
            if (app_cmd_en && app_cmd_ready) begin
                if (app_cmd == APP_CMD_WRITE && app_wdf_wren && app_wdf_end
                    && app_wdf_rdy) begin
                    wr_word = read_word(app_addr);
                    for (int b = 0; b < `MB_STRB_WIDTH; b++) begin
                        if (!app_wdf.mask[b]) begin
                            wr_word[b*8 +: 8] = app_wdf.data[b*8 +: 8];
                        end
                    end
                    mem[app_addr] = wr_word;
                end else if (app_cmd == APP_CMD_READ) begin
                    rd_pending <= 1'b1;
                    rd_wait    <= 1 + $urandom % 4;
                    rd_word    <= read_word(app_addr);
                end
            end
            // One pulse once the latency runs out
            if (rd_pending) begin
                if (rd_wait == 1) begin
                    app_rd_data_valid <= 1'b1;
                    app_rd_data       <= rd_word;
                    rd_pending        <= 1'b0;
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
        end
    end

endmodule

//--- sim/tb_mem_bridge.sv
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module tb_mem_bridge;
    import mem_bridge_pkg::*;

    localparam int NUM_CMDS    = 400;
    localparam int MAX_CYCLES  = NUM_CMDS * 20;
    localparam int DRAIN_LIMIT = 200;
    // Base of the 16-entry address window
    localparam logic [`MB_ADDR_WIDTH-1:0] WIN_BASE = 29'h0012_3400;

    logic                      clk_if = 1'b0;
    logic                      resetn;
    ram_cmd_t                  ram_cmd;
    logic                      ram_cmd_valid;
    logic                      ram_cmd_ready;
    rd_resp_t                  rd_resp;
    logic                      rd_resp_valid;
    logic                      rd_resp_ready;
    logic                      app_cmd_ready;
    logic                      app_wdf_rdy;
    app_cmd_e                  app_cmd;
    logic [`MB_ADDR_WIDTH-1:0] app_addr;
    logic                      app_cmd_en;
    app_wr_t                   app_wdf;
    logic                      app_wdf_wren;
    logic                      app_wdf_end;
    logic [`MB_DATA_WIDTH-1:0] app_rd_data;
    logic                      app_rd_data_valid;

    logic [`MB_DATA_WIDTH-1:0] ref_mem [logic [`MB_ADDR_WIDTH-1:0]];
    ram_cmd_t                  exp_cmds [$];
    rd_resp_t                  exp_resps [$];
    ram_cmd_t                  exp_cmd;
    rd_resp_t                  exp_resp;
    app_cmd_e                  exp_code;
    int unsigned               cycle_count = 0;
    int unsigned               accepted = 0;
    int unsigned               reads = 0;
    int unsigned               app_cmds = 0;
    int unsigned               resps = 0;
    logic                      stim_done = 1'b0;
    logic                      saw_cmd_full = 1'b0;

    always #50 clk_if = ~clk_if;

    mem_bridge_top i_dut (.*);

    app_mem_model i_app_mem (.*);

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("FAIL %0t: %s", $time, msg));
    endtask

    // Untouched locations hold a pattern of their address
    function automatic logic [`MB_DATA_WIDTH-1:0] ref_word(
        input logic [`MB_ADDR_WIDTH-1:0] addr
    );
        logic [31:0] seed;
        seed = {3'b000, addr} ^ 32'h9e37_79b9;
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return {seed, ~seed, seed + 32'h1, seed ^ 32'hffff_0000};
    endfunction

    function automatic logic [`MB_DATA_WIDTH-1:0] merge_bytes(
        input logic [`MB_DATA_WIDTH-1:0] old_word,
        input logic [`MB_DATA_WIDTH-1:0] new_word,
        input logic [`MB_STRB_WIDTH-1:0] strb
    );
        logic [`MB_DATA_WIDTH-1:0] word;
        word = old_word;
        for (int b = 0; b < `MB_STRB_WIDTH; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return word;
    endfunction

    task automatic check_idle_outputs();
        assert (!ram_cmd_ready && !app_cmd_en && !app_wdf_wren && !app_wdf_end && !rd_resp_valid)
            else value_error($sformatf("outputs active in reset: ready %b en %b wren %b valid %b",
                                       ram_cmd_ready, app_cmd_en, app_wdf_wren, rd_resp_valid));
    endtask

    always @(posedge clk_if) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // Scoreboard update at each accepted command
    always @(posedge clk_if) begin
        if (resetn && ram_cmd_valid && ram_cmd_ready) begin
            accepted++;
            exp_cmds.push_back(ram_cmd);
            if (ram_cmd.op == RAM_OP_WRITE) begin
                ref_mem[ram_cmd.addr] = merge_bytes(ref_word(ram_cmd.addr), ram_cmd.wr_data,
                                                    ram_cmd.wr_strb);
            end else begin
                reads++;
                exp_resps.push_back('{id: ram_cmd.id, data: ref_word(ram_cmd.addr),
                                      last: ram_cmd.last});
            end
        end
        if (resetn && ram_cmd_valid && !ram_cmd_ready && accepted > 0) begin
            saw_cmd_full = 1'b1;
        end
    end

    always @(posedge clk_if) begin
        if (resetn && app_cmd_en && app_cmd_ready) begin
            app_cmds++;
            assert (exp_cmds.size() > 0)
                else abort_run("App command issued while no accepted command was pending");
            exp_cmd  = exp_cmds.pop_front();
            exp_code = (exp_cmd.op == RAM_OP_READ) ? APP_CMD_READ : APP_CMD_WRITE;
            assert (app_cmd == exp_code && app_addr == exp_cmd.addr)
                else value_error($sformatf("app cmd %0d addr %h, expected cmd %0d addr %h",
                                           app_cmd, app_addr, exp_code, exp_cmd.addr));
            if (exp_cmd.op == RAM_OP_WRITE) begin
                assert (app_wdf_wren && app_wdf_end && app_wdf_rdy
                        && app_wdf.data == exp_cmd.wr_data && app_wdf.mask == ~exp_cmd.wr_strb)
                    else value_error($sformatf("write %h: wren %b end %b data %h mask %h",
                                               app_addr, app_wdf_wren, app_wdf_end,
                                               app_wdf.data, app_wdf.mask));
            end else begin
                assert (!app_wdf_wren && !app_wdf_end)
                    else value_error("write data strobed together with a read command");
            end
        end
    end

    always @(posedge clk_if) begin
        if (resetn && rd_resp_valid && rd_resp_ready) begin
            resps++;
            assert (exp_resps.size() > 0)
                else abort_run("Read response returned while no read was pending");
            exp_resp = exp_resps.pop_front();
            assert (rd_resp == exp_resp)
                else value_error($sformatf("resp id %0h last %b data %h, expected %0h %b %h",
                                           rd_resp.id, rd_resp.last, rd_resp.data,
                                           exp_resp.id, exp_resp.last, exp_resp.data));
        end
    end

    // Response sink with long stalls and random toggling
    initial begin : resp_sink
        int unsigned len;
        logic        hold_low;
        rd_resp_ready = 1'b0;
        wait (resetn);
        @(posedge clk_if);
        repeat (80) @(posedge clk_if);
        while (!stim_done) begin
            len      = 1 + $urandom % 24;
            hold_low = ($urandom % 4 == 0);
            repeat (len) begin
                rd_resp_ready <= hold_low ? 1'b0 : ($urandom % 4 != 0);
                @(posedge clk_if);
            end
        end
        rd_resp_ready <= 1'b1;
    end

    initial begin : stimulus
        ram_cmd_t    cmd;
        int unsigned drain_cycles;
        resetn        = 1'b0;
        ram_cmd       = '0;
        ram_cmd_valid = 1'b0;
        void'($urandom(32'he692));
        for (int n = 0; n < 8; n++) begin
            @(posedge clk_if);
            if (n > 0) begin
                check_idle_outputs();
            end
        end
        resetn <= 1'b1;
        @(posedge clk_if);
        check_idle_outputs();
        while (!ram_cmd_ready) @(posedge clk_if);

        for (int n = 0; n < NUM_CMDS; n++) begin
            cmd.op      = ($urandom % 2 == 0) ? RAM_OP_WRITE : RAM_OP_READ;
            cmd.last    = 1'($urandom % 2);
            cmd.id      = `MB_ID_WIDTH'($urandom);
            cmd.addr    = WIN_BASE + `MB_ADDR_WIDTH'($urandom % 16);
            cmd.wr_data = {$urandom, $urandom, $urandom, $urandom};
            cmd.wr_strb = ($urandom % 4 == 0) ? '1 : `MB_STRB_WIDTH'($urandom);
            ram_cmd       <= cmd;
            ram_cmd_valid <= 1'b1;
            @(posedge clk_if);
            while (!ram_cmd_ready) @(posedge clk_if);
            if ($urandom % 4 == 0) begin
                ram_cmd_valid <= 1'b0;
                @(posedge clk_if);
            end
        end
        ram_cmd_valid <= 1'b0;
        stim_done = 1'b1;

        // Bounded wait for the queues to drain
        drain_cycles = 0;
        while ((exp_cmds.size() != 0 || exp_resps.size() != 0)
               && drain_cycles < DRAIN_LIMIT) begin
            @(posedge clk_if);
            drain_cycles++;
        end
        // Quiet period to catch stray responses
        repeat (20) @(posedge clk_if);
        assert (accepted == NUM_CMDS && app_cmds == accepted && resps == reads)
            else value_error($sformatf("accepted %0d app cmds %0d reads %0d responses %0d",
                                       accepted, app_cmds, reads, resps));
        assert (saw_cmd_full)
            else abort_run("Command ready never dropped while responses were held back");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/mem_bridge_pkg.sv
rtl/cmd_queue.sv
rtl/app_sequencer.sv
rtl/read_return_queue.sv
rtl/mem_bridge_top.sv
sim/app_mem_model.sv
sim/tb_mem_bridge.sv

//--- Makefile
# Verilator simulation of the memory command bridge

VERILATOR ?= verilator
TOP       ?= tb_mem_bridge
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed, see $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
